// ==== Bender.yml ====
package:
  name: rv_core

sources:
  - design/core_pkg.sv
  - design/bus_pkg.sv
  - design/fetch_unit.sv
  - design/load_store_unit.sv
  - design/decode_execute.sv
  - design/apb_arbiter.sv
  - design/rv_core_top.sv
  - target: test
    files:
      - tb/rv_core_properties.sv
      - tb/rv_core_tb.sv

// ==== design/apb_arbiter.sv ====
// Fixed-priority APB arbiter
`timescale 1ns/1ps
module apb_arbiter (
  input  logic               clk_i,
  input  logic               rst_ni,
  input  logic               f_psel_i,
  input  logic               f_penable_i,
  input  bus_pkg::bus_addr_t f_paddr_i,
  output bus_pkg::bus_data_t f_prdata_o,
  output logic               f_pready_o,
  input  logic               d_psel_i,
  input  logic               d_penable_i,
  input  logic               d_pwrite_i,
  input  bus_pkg::bus_addr_t d_paddr_i,
  input  bus_pkg::bus_data_t d_pwdata_i,
  output bus_pkg::bus_data_t d_prdata_o,
  output logic               d_pready_o,
  output logic               psel_o,
  output logic               penable_o,
  output logic               pwrite_o,
  output bus_pkg::bus_addr_t paddr_o,
  output bus_pkg::bus_data_t pwdata_o,
  input  bus_pkg::bus_data_t prdata_i,
  input  logic               pready_i
);

  typedef enum logic [1:0] {
    OWN_NONE,
    OWN_FETCH,
    OWN_DATA
  } owner_e;

  owner_e owner_q;
  owner_e grant;

  // data wins so an older load or store never waits behind a fetch
  always_comb begin
    grant = owner_q;
    if (owner_q == OWN_NONE) begin
      if (d_psel_i) begin
        grant = OWN_DATA;
      end else if (f_psel_i) begin
        grant = OWN_FETCH;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (!rst_ni) begin
      owner_q <= OWN_NONE;
    end else if (owner_q == OWN_NONE) begin
      owner_q <= grant;
    end else if (penable_o && pready_i) begin
      owner_q <= OWN_NONE;
    end
  end

  // the grant cycle is the setup phase on the external side
  assign psel_o    = (grant == OWN_DATA) ? d_psel_i : (grant == OWN_FETCH) && f_psel_i;
  assign penable_o = (owner_q == OWN_DATA) ? d_penable_i :
                     (owner_q == OWN_FETCH) && f_penable_i;
  assign pwrite_o  = (grant == OWN_DATA) && d_pwrite_i;
  assign paddr_o   = (grant == OWN_DATA) ? d_paddr_i : f_paddr_i;
  assign pwdata_o  = d_pwdata_i;

  assign f_pready_o = (owner_q == OWN_FETCH) && pready_i;
  assign d_pready_o = (owner_q == OWN_DATA) && pready_i;
  assign f_prdata_o = (owner_q == OWN_FETCH) ? prdata_i : '0;
  assign d_prdata_o = (owner_q == OWN_DATA) ? prdata_i : '0;

endmodule

// ==== design/bus_pkg.sv ====
// APB bus types
package bus_pkg;

  typedef logic [31:0] bus_addr_t;
  typedef logic [31:0] bus_data_t;

  // master side phases of one transfer
  typedef enum logic [1:0] {
    APB_IDLE,
    APB_SETUP,
    APB_ACCESS
  } apb_state_e;

endpackage

// ==== design/core_pkg.sv ====
// RV32I subset ISA types
package core_pkg;

  typedef logic [31:0] word_t;
  typedef logic [4:0]  reg_idx_t;
  typedef logic [6:0]  opcode_t;

  // operations the execute stage ALU can run
  typedef enum logic [2:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_AND,
    ALU_OR,
    ALU_XOR,
    ALU_SLT,
    ALU_PASS_B
  } alu_op_e;

  // major opcodes of the kept instructions
  localparam opcode_t OPC_LUI    = 7'b0110111;
  localparam opcode_t OPC_OP_IMM = 7'b0010011;
  localparam opcode_t OPC_OP     = 7'b0110011;
  localparam opcode_t OPC_LOAD   = 7'b0000011;
  localparam opcode_t OPC_STORE  = 7'b0100011;
  localparam opcode_t OPC_BRANCH = 7'b1100011;
  localparam opcode_t OPC_JAL    = 7'b1101111;
  localparam opcode_t OPC_SYSTEM = 7'b1110011;

  localparam word_t INSTR_EBREAK = 32'h0010_0073;

endpackage

// ==== design/decode_execute.sv ====
// Decode and execute stage
`timescale 1ns/1ps
module decode_execute (
  input  logic               clk_i,
  input  logic               rst_ni,
  input  logic               instr_valid_i,
  input  core_pkg::word_t    instr_i,
  input  core_pkg::word_t    pc_i,
  output logic               take_o,
  output logic               redirect_o,
  output core_pkg::word_t    redirect_pc_o,
  output logic               mem_req_o,
  output logic               mem_we_o,
  output bus_pkg::bus_addr_t mem_addr_o,
  output bus_pkg::bus_data_t mem_wdata_o,
  input  logic               mem_done_i,
  input  core_pkg::word_t    mem_rdata_i,
  output logic               halted_o
);
  import core_pkg::*;

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_EXEC,
    ST_MEM,
    ST_HALT
  } ex_state_e;

  ex_state_e state_q;
  word_t     ir_q;
  word_t     pc_q;
  word_t     regs_q [32];

  opcode_t   opcode;
  reg_idx_t  rd;
  reg_idx_t  rs1;
  reg_idx_t  rs2;
  logic [2:0] funct3;
  word_t     rs1_val;
  word_t     rs2_val;
  word_t     imm_i;
  word_t     imm_s;
  word_t     imm_b;
  word_t     imm_u;
  word_t     imm_j;
  word_t     op_b;
  word_t     alu_res;
  alu_op_e   alu_op;
  logic      wr_en;
  logic      is_load;
  logic      is_store;
  logic      is_branch;
  logic      is_jal;
  logic      is_halt;
  logic      br_taken;

  ////////////////////////////////////////
  // field and immediate decode
  ////////////////////////////////////////
  assign opcode = ir_q[6:0];
  assign rd     = ir_q[11:7];
  assign funct3 = ir_q[14:12];
  assign rs1    = ir_q[19:15];
  assign rs2    = ir_q[24:20];

  assign imm_i = {{20{ir_q[31]}}, ir_q[31:20]};
  assign imm_s = {{20{ir_q[31]}}, ir_q[31:25], ir_q[11:7]};
  assign imm_b = {{19{ir_q[31]}}, ir_q[31], ir_q[7], ir_q[30:25], ir_q[11:8], 1'b0};
  assign imm_u = {ir_q[31:12], 12'h000};
  assign imm_j = {{11{ir_q[31]}}, ir_q[31], ir_q[19:12], ir_q[20], ir_q[30:21], 1'b0};

  // x0 always reads as zero
  assign rs1_val = (rs1 == 5'd0) ? '0 : regs_q[rs1];
  assign rs2_val = (rs2 == 5'd0) ? '0 : regs_q[rs2];

  always_comb begin
    wr_en     = 1'b0;
    is_load   = 1'b0;
    is_store  = 1'b0;
    is_branch = 1'b0;
    is_jal    = 1'b0;
    is_halt   = 1'b0;
    alu_op    = ALU_ADD;
    op_b      = rs2_val;
    unique case (opcode)
      OPC_LUI: begin
        wr_en  = 1'b1;
        alu_op = ALU_PASS_B;
        op_b   = imm_u;
      end
      OPC_OP_IMM: begin
        wr_en = funct3 == 3'b000;
        op_b  = imm_i;
      end
      OPC_OP: begin
        wr_en = 1'b1;
        case (funct3)
          3'b000:  alu_op = ir_q[30] ? ALU_SUB : ALU_ADD;
          3'b111:  alu_op = ALU_AND;
          3'b110:  alu_op = ALU_OR;
          3'b100:  alu_op = ALU_XOR;
          3'b010:  alu_op = ALU_SLT;
          default: wr_en = 1'b0;
        endcase
      end
      OPC_LOAD: begin
        is_load = funct3 == 3'b010;
        op_b    = imm_i;
      end
      OPC_STORE: begin
        is_store = funct3 == 3'b010;
        op_b     = imm_s;
      end
      OPC_BRANCH: is_branch = funct3[2:1] == 2'b00;
      OPC_JAL: begin
        is_jal = 1'b1;
        wr_en  = 1'b1;
      end
      OPC_SYSTEM: is_halt = ir_q == INSTR_EBREAK;
      default: ;
    endcase
  end

  ////////////////////////////////////////
  // ALU and branch resolution
  ////////////////////////////////////////
  always_comb begin
    unique case (alu_op)
      ALU_SUB:    alu_res = rs1_val - op_b;
      ALU_AND:    alu_res = rs1_val & op_b;
      ALU_OR:     alu_res = rs1_val | op_b;
      ALU_XOR:    alu_res = rs1_val ^ op_b;
      ALU_SLT:    alu_res = {31'b0, $signed(rs1_val) < $signed(op_b)};
      ALU_PASS_B: alu_res = op_b;
      default:    alu_res = rs1_val + op_b;
    endcase
  end

  // funct3[0] selects BNE over BEQ
  assign br_taken      = is_branch && ((rs1_val == rs2_val) ^ funct3[0]);
  assign redirect_o    = (state_q == ST_EXEC) && (is_jal || br_taken);
  assign redirect_pc_o = is_jal ? pc_q + imm_j : pc_q + imm_b;

  assign take_o      = (state_q == ST_IDLE) && instr_valid_i;
  assign mem_req_o   = state_q == ST_MEM;
  assign mem_we_o    = is_store;
  assign mem_addr_o  = alu_res;
  assign mem_wdata_o = rs2_val;
  assign halted_o    = state_q == ST_HALT;

  always_ff @(posedge clk_i) begin
    if (!rst_ni) begin
      state_q <= ST_IDLE;
    end else begin
      unique case (state_q)
        ST_IDLE: if (take_o) state_q <= ST_EXEC;
        ST_EXEC: begin
          if (is_halt) begin
            state_q <= ST_HALT;
          end else if (is_load || is_store) begin
            state_q <= ST_MEM;
          end else begin
            state_q <= ST_IDLE;
          end
        end
        ST_MEM:  if (mem_done_i) state_q <= ST_IDLE;
        default: state_q <= ST_HALT;
      endcase
    end
  end

  // execute register and register file
  always_ff @(posedge clk_i) begin
    if (take_o) begin
      ir_q <= instr_i;
      pc_q <= pc_i;
    end
    if (state_q == ST_EXEC && wr_en && rd != 5'd0) begin
      regs_q[rd] <= is_jal ? pc_q + 32'd4 : alu_res;
    end else if (state_q == ST_MEM && mem_done_i && is_load && rd != 5'd0) begin
      regs_q[rd] <= mem_rdata_i;
    end
  end

endmodule

// ==== design/fetch_unit.sv ====
// Instruction fetch unit
`timescale 1ns/1ps
module fetch_unit #(
  parameter core_pkg::word_t BOOT_ADDR = 32'h0000_0000
) (
  input  logic               clk_i,
  input  logic               rst_ni,
  input  logic               redirect_i,
  input  core_pkg::word_t    redirect_pc_i,
  input  logic               take_i,
  output logic               instr_valid_o,
  output core_pkg::word_t    instr_o,
  output core_pkg::word_t    pc_o,
  output logic               psel_o,
  output logic               penable_o,
  output bus_pkg::bus_addr_t paddr_o,
  input  bus_pkg::bus_data_t prdata_i,
  input  logic               pready_i
);
  import core_pkg::*;
  import bus_pkg::*;

  apb_state_e state_q;
  word_t      pc_q;
  bus_addr_t  paddr_q;
  logic       buf_valid_q;
  word_t      buf_instr_q;
  word_t      buf_pc_q;
  logic       drop_q;
  logic       start;
  logic       xfer_done;
  logic       keep;

  // a new read begins once the buffer is free or being taken
  assign start     = (state_q == APB_IDLE) && !redirect_i && (!buf_valid_q || take_i);
  assign xfer_done = (state_q == APB_ACCESS) && pready_i;
  assign keep      = xfer_done && !drop_q && !redirect_i;

  always_ff @(posedge clk_i) begin
    if (!rst_ni) begin
      state_q     <= APB_IDLE;
      pc_q        <= BOOT_ADDR;
      buf_valid_q <= 1'b0;
      drop_q      <= 1'b0;
    end else begin
      unique case (state_q)
        APB_IDLE:   if (start) state_q <= APB_SETUP;
        APB_SETUP:  state_q <= APB_ACCESS;
        APB_ACCESS: if (pready_i) state_q <= APB_IDLE;
        default:    state_q <= APB_IDLE;
      endcase
      if (redirect_i) begin
        pc_q <= redirect_pc_i;
      end else if (keep) begin
        pc_q <= pc_q + 32'd4;
      end
      if (redirect_i || take_i) begin
        buf_valid_q <= 1'b0;
      end else if (keep) begin
        buf_valid_q <= 1'b1;
      end
      // wrong path read still on the bus
      if (xfer_done) begin
        drop_q <= 1'b0;
      end else if (redirect_i && state_q != APB_IDLE) begin
        drop_q <= 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (start) paddr_q <= pc_q;
    if (keep) begin
      buf_instr_q <= prdata_i;
      buf_pc_q    <= paddr_q;
    end
  end

  assign psel_o        = state_q != APB_IDLE;
  assign penable_o     = state_q == APB_ACCESS;
  assign paddr_o       = paddr_q;
  assign instr_valid_o = buf_valid_q;
  assign instr_o       = buf_instr_q;
  assign pc_o          = buf_pc_q;

endmodule

// ==== design/load_store_unit.sv ====
// Load/store bus master
`timescale 1ns/1ps
module load_store_unit (
  input  logic               clk_i,
  input  logic               rst_ni,
  input  logic               mem_req_i,
  input  logic               mem_we_i,
  input  bus_pkg::bus_addr_t mem_addr_i,
  input  bus_pkg::bus_data_t mem_wdata_i,
  output logic               mem_done_o,
  output core_pkg::word_t    mem_rdata_o,
  output logic               psel_o,
  output logic               penable_o,
  output logic               pwrite_o,
  output bus_pkg::bus_addr_t paddr_o,
  output bus_pkg::bus_data_t pwdata_o,
  input  bus_pkg::bus_data_t prdata_i,
  input  logic               pready_i
);
  import bus_pkg::*;

  apb_state_e state_q;
  logic       done_q;
  logic       hold_q;
  bus_data_t  rdata_q;
  logic       xfer_done;

  assign xfer_done = (state_q == APB_ACCESS) && pready_i;

  always_ff @(posedge clk_i) begin
    if (!rst_ni) begin
      state_q <= APB_IDLE;
      done_q  <= 1'b0;
      hold_q  <= 1'b0;
    end else begin
      unique case (state_q)
        APB_IDLE:   if (mem_req_i && !hold_q) state_q <= APB_SETUP;
        APB_SETUP:  state_q <= APB_ACCESS;
        APB_ACCESS: if (pready_i) state_q <= APB_IDLE;
        default:    state_q <= APB_IDLE;
      endcase
      done_q <= xfer_done;
      // served request must drop before the next one
      if (xfer_done) begin
        hold_q <= 1'b1;
      end else if (!mem_req_i) begin
        hold_q <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (xfer_done) rdata_q <= prdata_i;
  end

  // request fields are held by the execute stage for the whole transfer
  assign psel_o      = state_q != APB_IDLE;
  assign penable_o   = state_q == APB_ACCESS;
  assign pwrite_o    = mem_we_i;
  assign paddr_o     = mem_addr_i;
  assign pwdata_o    = mem_wdata_i;
  assign mem_done_o  = done_q;
  assign mem_rdata_o = rdata_q;

endmodule

// ==== design/rv_core_top.sv ====
// RV32I subset core top
`timescale 1ns/1ps
module rv_core_top #(
  parameter core_pkg::word_t BOOT_ADDR = 32'h0000_0000
) (
  input  logic               clk_i,
  input  logic               rst_ni,
  output logic               psel_o,
  output logic               penable_o,
  output logic               pwrite_o,
  output bus_pkg::bus_addr_t paddr_o,
  output bus_pkg::bus_data_t pwdata_o,
  input  bus_pkg::bus_data_t prdata_i,
  input  logic               pready_i,
  output logic               halted_o
);
  import core_pkg::*;
  import bus_pkg::*;

  ////////////////////////////////////////
  // fetch to execute
  ////////////////////////////////////////
  logic      instr_valid;
  word_t     instr;
  word_t     instr_pc;
  logic      take;
  logic      redirect;
  word_t     redirect_pc;

  // execute to load/store
  logic      mem_req;
  logic      mem_we;
  bus_addr_t mem_addr;
  bus_data_t mem_wdata;
  logic      mem_done;
  word_t     mem_rdata;

  // master ports into the arbiter
  logic      f_psel;
  logic      f_penable;
  bus_addr_t f_paddr;
  bus_data_t f_prdata;
  logic      f_pready;
  logic      d_psel;
  logic      d_penable;
  logic      d_pwrite;
  bus_addr_t d_paddr;
  bus_data_t d_pwdata;
  bus_data_t d_prdata;
  logic      d_pready;

  fetch_unit #(
    .BOOT_ADDR(BOOT_ADDR)
  ) i_fetch_unit (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .redirect_i   (redirect),
    .redirect_pc_i(redirect_pc),
    .take_i       (take),
    .instr_valid_o(instr_valid),
    .instr_o      (instr),
    .pc_o         (instr_pc),
    .psel_o       (f_psel),
    .penable_o    (f_penable),
    .paddr_o      (f_paddr),
    .prdata_i     (f_prdata),
    .pready_i     (f_pready)
  );

  decode_execute i_decode_execute (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .instr_valid_i(instr_valid),
    .instr_i      (instr),
    .pc_i         (instr_pc),
    .take_o       (take),
    .redirect_o   (redirect),
    .redirect_pc_o(redirect_pc),
    .mem_req_o    (mem_req),
    .mem_we_o     (mem_we),
    .mem_addr_o   (mem_addr),
    .mem_wdata_o  (mem_wdata),
    .mem_done_i   (mem_done),
    .mem_rdata_i  (mem_rdata),
    .halted_o     (halted_o)
  );

  load_store_unit i_load_store_unit (
    .clk_i      (clk_i),
    .rst_ni     (rst_ni),
    .mem_req_i  (mem_req),
    .mem_we_i   (mem_we),
    .mem_addr_i (mem_addr),
    .mem_wdata_i(mem_wdata),
    .mem_done_o (mem_done),
    .mem_rdata_o(mem_rdata),
    .psel_o     (d_psel),
    .penable_o  (d_penable),
    .pwrite_o   (d_pwrite),
    .paddr_o    (d_paddr),
    .pwdata_o   (d_pwdata),
    .prdata_i   (d_prdata),
    .pready_i   (d_pready)
  );

  apb_arbiter i_apb_arbiter (
    .clk_i      (clk_i),
    .rst_ni     (rst_ni),
    .f_psel_i   (f_psel),
    .f_penable_i(f_penable),
    .f_paddr_i  (f_paddr),
    .f_prdata_o (f_prdata),
    .f_pready_o (f_pready),
    .d_psel_i   (d_psel),
    .d_penable_i(d_penable),
    .d_pwrite_i (d_pwrite),
    .d_paddr_i  (d_paddr),
    .d_pwdata_i (d_pwdata),
    .d_prdata_o (d_prdata),
    .d_pready_o (d_pready),
    .psel_o     (psel_o),
    .penable_o  (penable_o),
    .pwrite_o   (pwrite_o),
    .paddr_o    (paddr_o),
    .pwdata_o   (pwdata_o),
    .prdata_i   (prdata_i),
    .pready_i   (pready_i)
  );

endmodule

// ==== flist.f ====
design/core_pkg.sv
design/bus_pkg.sv
design/fetch_unit.sv
design/load_store_unit.sv
design/decode_execute.sv
design/apb_arbiter.sv
design/rv_core_top.sv
tb/rv_core_properties.sv
tb/rv_core_tb.sv

// ==== tb/rv_core_properties.sv ====
// APB protocol and halt checks
`timescale 1ns/1ps
module rv_core_properties #(
  parameter core_pkg::word_t BOOT_ADDR = 32'h0000_0000
) (
  input logic               clk_i,
  input logic               rst_ni,
  input logic               psel_o,
  input logic               penable_o,
  input logic               pwrite_o,
  input bus_pkg::bus_addr_t paddr_o,
  input bus_pkg::bus_data_t pwdata_o,
  input logic               pready_i,
  input logic               halted_o
);

  int unsigned fail_count = 0;

  ////////////////////////////////////////
  // reset and first fetch
  ////////////////////////////////////////
  reset_idle: assert property (@(posedge clk_i)
    !rst_ni |=> !psel_o && !penable_o && !halted_o)
    else begin
      fail_count++;
      $error("bus or halt active after a reset cycle");
    end

  first_fetch: assert property (@(posedge clk_i)
    $rose(rst_ni) |=> psel_o && !penable_o && !pwrite_o && paddr_o == BOOT_ADDR)
    else begin
      fail_count++;
      $error("first transfer is not a read setup at the boot address");
    end

  ////////////////////////////////////////
  // APB phases
  ////////////////////////////////////////
  enable_needs_select: assert property (@(posedge clk_i) disable iff (!rst_ni)
    penable_o |-> psel_o)
    else begin
      fail_count++;
      $error("penable high without psel");
    end

  setup_then_access: assert property (@(posedge clk_i) disable iff (!rst_ni)
    psel_o && !penable_o |=> psel_o && penable_o)
    else begin
      fail_count++;
      $error("setup cycle not followed by an access cycle");
    end

  // write data only matters on writes
  stable_while_waiting: assert property (@(posedge clk_i) disable iff (!rst_ni)
    penable_o && !pready_i |=>
      $stable(paddr_o) && $stable(pwrite_o) && (!pwrite_o || $stable(pwdata_o)))
    else begin
      fail_count++;
      $error("address, direction or write data changed during wait states");
    end

  ////////////////////////////////////////
  // halt
  ////////////////////////////////////////
  halt_sticky: assert property (@(posedge clk_i) disable iff (!rst_ni)
    halted_o |=> halted_o)
    else begin
      fail_count++;
      $error("halted dropped before reset");
    end

  quiet_after_halt: assert property (@(posedge clk_i) disable iff (!rst_ni)
    halted_o && !psel_o |=> !psel_o)
    else begin
      fail_count++;
      $error("new transfer started after halt");
    end

endmodule

bind rv_core_top rv_core_properties #(
  .BOOT_ADDR(BOOT_ADDR)
) i_rv_core_properties (
  .clk_i    (clk_i),
  .rst_ni   (rst_ni),
  .psel_o   (psel_o),
  .penable_o(penable_o),
  .pwrite_o (pwrite_o),
  .paddr_o  (paddr_o),
  .pwdata_o (pwdata_o),
  .pready_i (pready_i),
  .halted_o (halted_o)
);

// ==== tb/rv_core_tb.sv ====
// RV32I subset core testbench
`timescale 1ns/1ps
module rv_core_tb;

  localparam logic [31:0] BOOT_ADDR    = 32'h0000_0100;
  localparam logic [31:0] RESULT_BASE  = 32'h0000_0300;
  localparam logic [31:0] POISON_ADDR  = 32'h0000_03FC;
  localparam int          HALT_TIMEOUT = 5000;
  localparam int          IDLE_TIMEOUT = 50;

  logic        clk_i;
  logic        rst_ni;
  logic        psel;
  logic        penable;
  logic        pwrite;
  logic [31:0] paddr;
  logic [31:0] pwdata;
  logic [31:0] prdata;
  logic        pready;
  logic        halted;

  // 1 KiB word memory with the program at BOOT_ADDR and data at 0x200
  logic [31:0] mem [256];
  logic [31:0] exp_addr [$];
  logic [31:0] exp_data [$];
  string       exp_name [$];
  logic [31:0] prog_pc;
  logic [31:0] draw;
  logic [31:0] a;
  logic [31:0] b;
  logic [31:0] jal_pc;
  integer      seed;
  int          wait_left;
  int          store_slot;
  int          cycles;
  int          check_errors;
  int          timeout_errors;
  int          prop_errors;

  rv_core_top #(
    .BOOT_ADDR(BOOT_ADDR)
  ) i_rv_core_top (
    .clk_i    (clk_i),
    .rst_ni   (rst_ni),
    .psel_o   (psel),
    .penable_o(penable),
    .pwrite_o (pwrite),
    .paddr_o  (paddr),
    .pwdata_o (pwdata),
    .prdata_i (prdata),
    .pready_i (pready),
    .halted_o (halted)
  );

  always #10 clk_i = ~clk_i;

  ////////////////////////////////////////
  // instruction encoders
  ////////////////////////////////////////
  function automatic logic [31:0] r_type(input logic [6:0] f7, input logic [4:0] rs2,
                                         input logic [4:0] rs1, input logic [2:0] f3,
                                         input logic [4:0] rd);
    return {f7, rs2, rs1, f3, rd, 7'b0110011};
  endfunction

  function automatic logic [31:0] i_type(input logic [11:0] imm, input logic [4:0] rs1,
                                         input logic [2:0] f3, input logic [4:0] rd,
                                         input logic [6:0] op);
    return {imm, rs1, f3, rd, op};
  endfunction

  function automatic logic [31:0] s_type(input logic [11:0] imm, input logic [4:0] rs2);
    return {imm[11:5], rs2, 5'd0, 3'b010, imm[4:0], 7'b0100011};
  endfunction

  function automatic logic [31:0] b_type(input logic [12:0] imm, input logic [4:0] rs2,
                                         input logic [4:0] rs1, input logic [2:0] f3);
    return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], 7'b1100011};
  endfunction

  function automatic logic [31:0] j_type(input logic [20:0] imm, input logic [4:0] rd);
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'b1101111};
  endfunction

  task automatic emit(input logic [31:0] instr);
    mem[prog_pc[9:2]] = instr;
    prog_pc = prog_pc + 32'd4;
  endtask

  // store rs2 to the next result slot and record what it must hold
  task automatic store_and_expect(input logic [4:0] rs2, input logic [31:0] value,
                                  input string name);
    logic [31:0] addr;
    addr = RESULT_BASE + 32'(store_slot * 4);
    store_slot++;
    emit(s_type(addr[11:0], rs2));
    exp_addr.push_back(addr);
    exp_data.push_back(value);
    exp_name.push_back(name);
  endtask

  task automatic op_and_store(input logic [6:0] f7, input logic [2:0] f3, input logic [4:0] rs1,
                              input logic [4:0] rs2, input logic [4:0] rd,
                              input logic [31:0] value, input string name);
    emit(r_type(f7, rs2, rs1, f3, rd));
    store_and_expect(rd, value, name);
  endtask

  // taken branch over a poison store
  task automatic skip_store(input logic [2:0] f3, input logic [4:0] rs1, input logic [4:0] rs2);
    emit(b_type(13'd8, rs2, rs1, f3));
    emit(s_type(POISON_ADDR[11:0], 5'd20));
  endtask

  task automatic check_store(input logic [31:0] addr, input logic [31:0] data);
    logic [31:0] want_addr;
    logic [31:0] want_data;
    string       name;
    assert (addr != POISON_ADDR) else begin
      check_errors++;
      $display("store of %h hit the poison address, a skipped store was executed", data);
    end
    if (addr != POISON_ADDR) begin
      assert (exp_addr.size() > 0) else begin
        check_errors++;
        $display("unexpected store of %h to %h after all expected stores", data, addr);
      end
      if (exp_addr.size() > 0) begin
        want_addr = exp_addr.pop_front();
        want_data = exp_data.pop_front();
        name = exp_name.pop_front();
        assert (addr == want_addr) else begin
          check_errors++;
          $display("CHECK FAILED %s address: expected %h actual %h", name, want_addr, addr);
        end
        assert (data == want_data) else begin
          check_errors++;
          $display("CHECK FAILED %s value: expected %h actual %h", name, want_data, data);
        end
      end
    end
  endtask

  ////////////////////////////////////////
  // APB memory model
  ////////////////////////////////////////
  always @(negedge clk_i) begin
    if (rst_ni && psel && penable) begin
      if (wait_left > 0) begin
        wait_left--;
      end else begin
        pready = 1'b1;
        assert (paddr[31:10] == 22'd0) else begin
          check_errors++;
          $display("bus access at %h is outside the memory", paddr);
        end
        if (pwrite) begin
          check_store(paddr, pwdata);
          mem[paddr[9:2]] = pwdata;
        end else begin
          prdata = mem[paddr[9:2]];
        end
      end
    end else begin
      pready = 1'b0;
      // wait states of this transfer are drawn in its setup phase
      if (rst_ni && psel) begin
        draw = $random(seed);
        wait_left = int'(draw[1:0]);
      end
    end
  end

  initial begin
    clk_i = 1'b0;
    rst_ni = 1'b0;
    prdata = '0;
    pready = 1'b0;
    seed = 32'h4119;
    wait_left = 0;
    store_slot = 0;
    check_errors = 0;
    timeout_errors = 0;
    for (int i = 0; i < 256; i++) begin
      mem[i] = 32'h6B00_0000 | (32'(i) << 2);
    end
    for (int i = 128; i < 144; i++) begin
      mem[i] = $random(seed);
    end

    a = 32'h0000_05A3;
    b = {{20{1'b1}}, 12'hEDD};
    prog_pc = BOOT_ADDR;
    emit(i_type(12'h5A3, 5'd0, 3'b000, 5'd1, 7'b0010011));
    emit(i_type(12'hEDD, 5'd0, 3'b000, 5'd2, 7'b0010011));
    store_and_expect(5'd1, a, "addi");
    op_and_store(7'h00, 3'b000, 5'd1, 5'd2, 5'd3, a + b, "add");
    op_and_store(7'h20, 3'b000, 5'd1, 5'd2, 5'd4, a - b, "sub");
    op_and_store(7'h00, 3'b111, 5'd1, 5'd2, 5'd5, a & b, "and");
    op_and_store(7'h00, 3'b110, 5'd1, 5'd2, 5'd6, a | b, "or");
    op_and_store(7'h00, 3'b100, 5'd1, 5'd2, 5'd7, a ^ b, "xor");
    // b is negative and a positive
    op_and_store(7'h00, 3'b010, 5'd2, 5'd1, 5'd8, 32'd1, "slt_true");
    op_and_store(7'h00, 3'b010, 5'd1, 5'd2, 5'd9, 32'd0, "slt_false");
    emit({20'hDEADB, 5'd10, 7'b0110111});
    store_and_expect(5'd10, 32'hDEAD_B000, "lui");
    emit(i_type(12'h7EF, 5'd10, 3'b000, 5'd11, 7'b0010011));
    store_and_expect(5'd11, 32'hDEAD_B000 + 32'h0000_07EF, "addi_reg");

    // three loads from the random data region and their sum
    emit(i_type(12'h200, 5'd0, 3'b010, 5'd12, 7'b0000011));
    emit(i_type(12'h204, 5'd0, 3'b010, 5'd13, 7'b0000011));
    emit(i_type(12'h208, 5'd0, 3'b010, 5'd14, 7'b0000011));
    emit(r_type(7'h00, 5'd13, 5'd12, 3'b000, 5'd15));
    op_and_store(7'h00, 3'b000, 5'd15, 5'd14, 5'd15, mem[128] + mem[129] + mem[130], "load_sum");

    // control flow
    emit(i_type(12'hFFF, 5'd0, 3'b000, 5'd20, 7'b0010011));
    skip_store(3'b000, 5'd1, 5'd1);
    skip_store(3'b001, 5'd1, 5'd2);
    emit(b_type(13'd8, 5'd2, 5'd1, 3'b000));
    store_and_expect(5'd1, a, "beq_fall");
    emit(b_type(13'd8, 5'd1, 5'd1, 3'b001));
    store_and_expect(5'd2, b, "bne_fall");
    jal_pc = prog_pc;
    emit(j_type(21'd8, 5'd21));
    emit(s_type(POISON_ADDR[11:0], 5'd20));
    store_and_expect(5'd21, jal_pc + 32'd4, "jal_link");
    emit(32'h0010_0073);

    repeat (16) @(negedge clk_i);
    rst_ni = 1'b1;

    cycles = 0;
    while (!halted && cycles < HALT_TIMEOUT) begin
      @(negedge clk_i);
      cycles++;
    end
    if (!halted) begin
      timeout_errors++;
      $display("timeout: the core did not halt within %0d cycles", HALT_TIMEOUT);
    end else begin
      cycles = 0;
      while (psel && cycles < IDLE_TIMEOUT) begin
        @(negedge clk_i);
        cycles++;
      end
      if (psel) begin
        timeout_errors++;
        $display("timeout: the bus stayed busy for %0d cycles after halt", IDLE_TIMEOUT);
      end
      // let the bound checks watch the idle bus for a while
      repeat (10) @(negedge clk_i);
    end

    assert (exp_addr.size() == 0) else begin
      check_errors++;
      $display("%0d expected stores never happened, first missing is %s",
               exp_addr.size(), exp_name[0]);
    end
    prop_errors = i_rv_core_top.i_rv_core_properties.fail_count;
    $display("errors: %0d store checks, %0d protocol assertions, %0d timeouts",
             check_errors, prop_errors, timeout_errors);
    if (check_errors + prop_errors + timeout_errors == 0) begin
      $display("TESTBENCH PASSED");
    end else begin
      $display("TESTBENCH FAILED");
    end
    $finish;
  end

endmodule
